/* beat_capture.sv */
`timescale 1ns/10ps
`default_nettype none

module beat_capture (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire cut_out_pkg::cut_event_t       evt,
  input  wire [cut_out_pkg::SHIFT_W-1:0]     st_shift_reg,
  input  wire [3:0]                          rx_cnt_low,
  output cut_out_pkg::rx_beat_t              sq_rx_beat
);

  logic       load;
  logic       last_beat;
  logic [3:0] empty_full;

  // vsync loads on shift count alone, no frame checks
  assign load = evt.head_hit || evt.vsync_shift || evt.sqcut_hit ||
                evt.sqrcut_hit || evt.sqcut_end_hit || evt.sqrcut_end_raw;

  assign last_beat  = evt.head_hit || evt.sqcut_end_hit;
  assign empty_full = 4'(cut_out_pkg::BEAT_BYTES) - rx_cnt_low;

  //////////////////////////////
  // data beat
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sq_rx_beat.data <= '0;
    end else if (load) begin
      sq_rx_beat.data <= st_shift_reg[cut_out_pkg::BEAT_LSB +: cut_out_pkg::BEAT_BYTES*8];
    end
  end

  // empty only counts on the closing beat
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sq_rx_beat.empty <= '0;
    end else if (last_beat) begin
      sq_rx_beat.empty <= empty_full[2:0];
    end else begin
      sq_rx_beat.empty <= '0;
    end
  end

endmodule

`default_nettype wire

/* cut_event_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module cut_event_decode (
  input  wire cut_out_pkg::cut_state_t  state,
  input  wire cut_out_pkg::frame_info_t info,
  output cut_out_pkg::cut_event_t       evt
);

  logic [15:0] shift_ext;
  logic [16:0] len_limit;
  logic        shift_ge_rx;
  logic        shift_ge_min;
  logic        shift_ge_sub;
  logic        len_ok;
  logic        tags_ok;

  //////////////////////////////
  // shared compares
  //////////////////////////////
  assign shift_ext    = {10'd0, info.shift_ccnt};
  assign shift_ge_rx  = shift_ext >= info.rx_cnt;
  assign shift_ge_min = info.shift_ccnt >= 6'(cut_out_pkg::MIN_SHIFT);
  assign shift_ge_sub = info.shift_ccnt >= info.sub_len;

  // one extra bit so the padded length never wraps
  assign len_limit = {1'b0, info.sync_len} + 17'(cut_out_pkg::LEN_PAD);
  assign len_ok    = {1'b0, info.rx_cnt} < len_limit;

  assign tags_ok = (info.sync_first == cut_out_pkg::SYNC_FIRST_TAG) &&
                   (info.sync_four == cut_out_pkg::SYNC_FOUR_TAG);

  //////////////////////////////
  // qualified hits
  //////////////////////////////
  always_comb begin
    evt.head_hit       = state.sqcuth && shift_ge_rx;
    evt.vsync_shift    = state.vsync && shift_ge_min;
    evt.vsync_ok       = evt.vsync_shift && len_ok &&
                         info.frame_flag && info.sqid_flag;
    evt.vsync_tagged   = evt.vsync_ok && tags_ok;
    evt.sqcut_hit      = state.sqcut && shift_ge_min;
    evt.sqcut_end_hit  = state.sqcut_end && shift_ge_rx;
    evt.sqrcut_hit     = state.sqrcut && shift_ge_min;
    evt.sqrcut_end_hit = state.sqrcut_end && shift_ge_sub;
    // beat loads on re-cut end even when the length check fails
    evt.sqrcut_end_raw = state.sqrcut_end;
  end

endmodule

`default_nettype wire

/* cut_out_pkg.sv */
`default_nettype none

package cut_out_pkg;

  //////////////////////////////
  // sizes and thresholds
  //////////////////////////////
  localparam int LANES      = 32;
  localparam int BEAT_BYTES = 8;
  localparam int SHIFT_W    = 192;
  // beat is the top 64 bits of the shift register
  localparam int BEAT_LSB   = 128;
  localparam int MIN_SHIFT  = 8;
  localparam int LEN_PAD    = 4;

  // sync words a tagged vsync must carry
  localparam logic [15:0] SYNC_FIRST_TAG = 16'h0200;
  localparam logic [31:0] SYNC_FOUR_TAG  = 32'h0100_044c;

  //////////////////////////////
  // types
  //////////////////////////////
  typedef logic [LANES-1:0]          lane_mask_t;
  typedef logic [BEAT_BYTES*8-1:0]   beat_t;
  typedef logic [2:0]                empty_t;
  typedef logic [15:0]               byte_cnt_t;

  // one strobe per parser state
  typedef struct packed {
    logic sqcuth;
    logic vsync;
    logic sqcut;
    logic sqcut_end;
    logic sqrcut;
    logic sqrcut_end;
  } cut_state_t;

  typedef struct packed {
    lane_mask_t cut_on;
    lane_mask_t cut_first_on;
    lane_mask_t tcp_match;
  } lane_flags_t;

  typedef struct packed {
    logic [5:0]  shift_ccnt;
    logic [15:0] rx_cnt;
    logic [15:0] sync_len;
    logic [15:0] sync_first;
    logic [31:0] sync_four;
    logic        frame_flag;
    logic        sqid_flag;
    logic [5:0]  sub_len;
  } frame_info_t;

  // qualified hits from the decoder
  typedef struct packed {
    logic head_hit;
    logic vsync_ok;
    logic vsync_tagged;
    logic vsync_shift;
    logic sqcut_hit;
    logic sqcut_end_hit;
    logic sqrcut_hit;
    logic sqrcut_end_hit;
    logic sqrcut_end_raw;
  } cut_event_t;

  typedef struct packed {
    beat_t  data;
    empty_t empty;
  } rx_beat_t;

endpackage

`default_nettype wire

/* fir_cut_out.sv */
`timescale 1ns/10ps
`default_nettype none

module fir_cut_out (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire cut_out_pkg::cut_state_t    state,
  input  wire cut_out_pkg::lane_flags_t   flags,
  input  wire cut_out_pkg::frame_info_t   info,
  input  wire [cut_out_pkg::SHIFT_W-1:0]  st_shift_reg,
  output wire cut_out_pkg::lane_mask_t    sq_rx_start,
  output wire cut_out_pkg::lane_mask_t    sq_rx_valid,
  output wire cut_out_pkg::rx_beat_t      sq_rx_beat,
  output wire cut_out_pkg::byte_cnt_t     sq_rx_cnt
);

  cut_out_pkg::cut_event_t evt;

  //////////////////////////////
  // condition decode
  //////////////////////////////
  cut_event_decode u_event (
    .state (state),
    .info  (info),
    .evt   (evt)
  );

  //////////////////////////////
  // masks and beat
  //////////////////////////////
  lane_mask_gen u_mask (
    .clk         (clk),
    .rst_n       (rst_n),
    .evt         (evt),
    .flags       (flags),
    .sq_rx_start (sq_rx_start),
    .sq_rx_valid (sq_rx_valid)
  );

  beat_capture u_beat (
    .clk          (clk),
    .rst_n        (rst_n),
    .evt          (evt),
    .st_shift_reg (st_shift_reg),
    .rx_cnt_low   (info.rx_cnt[3:0]),
    .sq_rx_beat   (sq_rx_beat)
  );

  // tally runs one cycle behind the masks
  rx_byte_tally u_tally (
    .clk         (clk),
    .rst_n       (rst_n),
    .sq_rx_start (sq_rx_start),
    .sq_rx_valid (sq_rx_valid),
    .sq_rx_beat  (sq_rx_beat),
    .sq_rx_cnt   (sq_rx_cnt)
  );

endmodule

`default_nettype wire

/* lane_mask_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module lane_mask_gen (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire cut_out_pkg::cut_event_t  evt,
  input  wire cut_out_pkg::lane_flags_t flags,
  output cut_out_pkg::lane_mask_t       sq_rx_start,
  output cut_out_pkg::lane_mask_t       sq_rx_valid
);

  cut_out_pkg::lane_mask_t first_free;

  // lowest lane with cut_on clear, zero when all lanes busy
  assign first_free = ~flags.cut_on & (flags.cut_on + 1'b1);

  //////////////////////////////
  // start mask
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sq_rx_start <= '0;
    end else if (evt.head_hit) begin
      sq_rx_start <= flags.cut_first_on;
    end else if (evt.vsync_tagged) begin
      sq_rx_start <= first_free;
    end else begin
      sq_rx_start <= '0;
    end
  end

  //////////////////////////////
  // valid mask
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sq_rx_valid <= '0;
    end else if (evt.head_hit) begin
      sq_rx_valid <= flags.cut_first_on;
    end else if (evt.vsync_ok) begin
      // untagged vsync still opens the lane
      sq_rx_valid <= first_free;
    end else if (evt.sqcut_hit) begin
      sq_rx_valid <= flags.cut_first_on;
    end else if (evt.sqcut_end_hit) begin
      sq_rx_valid <= flags.cut_first_on;
    end else if (evt.sqrcut_hit) begin
      sq_rx_valid <= flags.tcp_match;
    end else if (evt.sqrcut_end_hit) begin
      sq_rx_valid <= flags.tcp_match;
    end else begin
      sq_rx_valid <= '0;
    end
  end

endmodule

`default_nettype wire

/* project.f */
cut_out_pkg.sv
cut_event_decode.sv
lane_mask_gen.sv
beat_capture.sv
rx_byte_tally.sv
fir_cut_out.sv
tb_clk_gen.sv
tb_fir_cut_out.sv

/* rx_byte_tally.sv */
`timescale 1ns/10ps
`default_nettype none

module rx_byte_tally (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire cut_out_pkg::lane_mask_t sq_rx_start,
  input  wire cut_out_pkg::lane_mask_t sq_rx_valid,
  input  wire cut_out_pkg::rx_beat_t   sq_rx_beat,
  output cut_out_pkg::byte_cnt_t       sq_rx_cnt
);

  cut_out_pkg::byte_cnt_t beat_bytes;

  // bytes carried by the current beat
  assign beat_bytes = cut_out_pkg::byte_cnt_t'(cut_out_pkg::BEAT_BYTES) -
                      {13'd0, sq_rx_beat.empty};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sq_rx_cnt <= '0;
    end else if (|sq_rx_start && |sq_rx_valid) begin
      // new frame restarts the tally
      sq_rx_cnt <= beat_bytes;
    end else if (|sq_rx_valid) begin
      sq_rx_cnt <= sq_rx_cnt + beat_bytes;
    end
  end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset held for two rising edges
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* tb_fir_cut_out.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_fir_cut_out;

  // strobe bits in cut_state_t order
  localparam logic [5:0] S_HEAD     = 6'b100000;
  localparam logic [5:0] S_VSYNC    = 6'b010000;
  localparam logic [5:0] S_CUT      = 6'b001000;
  localparam logic [5:0] S_CUT_END  = 6'b000100;
  localparam logic [5:0] S_RCUT     = 6'b000010;
  localparam logic [5:0] S_RCUT_END = 6'b000001;

  // reset release, then reset, head, vsync, re-cut, priority and tally tests
  localparam int TEST_CYCLES = 2 + 3 + 5 + 7 + 6 + 302 + 9;
  localparam int CYCLE_LIMIT = TEST_CYCLES * 3 / 2;

  logic clk;
  logic rst_n;
  cut_out_pkg::cut_state_t            state;
  cut_out_pkg::lane_flags_t           flags;
  cut_out_pkg::frame_info_t           info;
  logic [cut_out_pkg::SHIFT_W-1:0]    st_shift_reg;
  cut_out_pkg::lane_mask_t            sq_rx_start;
  cut_out_pkg::lane_mask_t            sq_rx_valid;
  cut_out_pkg::rx_beat_t              sq_rx_beat;
  cut_out_pkg::byte_cnt_t             sq_rx_cnt;

  cut_out_pkg::lane_mask_t exp_start;
  cut_out_pkg::lane_mask_t exp_valid;
  cut_out_pkg::beat_t      exp_data;
  cut_out_pkg::empty_t     exp_empty;
  cut_out_pkg::byte_cnt_t  exp_cnt;

  logic [31:0] rng_state = 32'h3d1;
  logic        check_on = 1'b0;
  int          check_count = 0;
  int          err_count = 0;
  int          test_count = 0;
  int          cycle_count = 0;
  int          checks_at_start;
  int          errs_at_start;

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  fir_cut_out u_fir_cut_out (
    .clk          (clk),
    .rst_n        (rst_n),
    .state        (state),
    .flags        (flags),
    .info         (info),
    .st_shift_reg (st_shift_reg),
    .sq_rx_start  (sq_rx_start),
    .sq_rx_valid  (sq_rx_valid),
    .sq_rx_beat   (sq_rx_beat),
    .sq_rx_cnt    (sq_rx_cnt)
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // one-hot lowest lane with cut_on clear
  function automatic cut_out_pkg::lane_mask_t first_free_lane(
    input cut_out_pkg::lane_mask_t busy
  );
    cut_out_pkg::lane_mask_t lane;
    logic                    found;
    lane = '0;
    found = 1'b0;
    for (int i = 0; i < cut_out_pkg::LANES; i++) begin
      if (!found && !busy[i]) begin
        lane[i] = 1'b1;
        found = 1'b1;
      end
    end
    return lane;
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////
  always @(posedge clk) begin : ref_model
    logic        head;
    logic        vs_shift;
    logic        vs_ok;
    logic        vs_tag;
    logic        cut;
    logic        cut_end;
    logic        rcut;
    logic        rcut_end;
    logic [15:0] tally_bytes;
    head     = state.sqcuth && ({10'd0, info.shift_ccnt} >= info.rx_cnt);
    vs_shift = state.vsync && (info.shift_ccnt >= 6'd8);
    vs_ok    = vs_shift && info.frame_flag && info.sqid_flag &&
               ({16'd0, info.rx_cnt} < {16'd0, info.sync_len} + 32'd4);
    vs_tag   = vs_ok && (info.sync_first == 16'h0200) && (info.sync_four == 32'h0100044c);
    cut      = state.sqcut && (info.shift_ccnt >= 6'd8);
    cut_end  = state.sqcut_end && ({10'd0, info.shift_ccnt} >= info.rx_cnt);
    rcut     = state.sqrcut && (info.shift_ccnt >= 6'd8);
    rcut_end = state.sqrcut_end && (info.shift_ccnt >= info.sub_len);
    tally_bytes = 16'd8 - {13'd0, exp_empty};
    if (!rst_n) begin
      exp_start <= '0;
      exp_valid <= '0;
      exp_data  <= '0;
      exp_empty <= '0;
      exp_cnt   <= '0;
    end else begin
      if (head) exp_start <= flags.cut_first_on;
      else if (vs_tag) exp_start <= first_free_lane(flags.cut_on);
      else exp_start <= '0;
      if (head) exp_valid <= flags.cut_first_on;
      else if (vs_ok) exp_valid <= first_free_lane(flags.cut_on);
      else if (cut || cut_end) exp_valid <= flags.cut_first_on;
      else if (rcut || rcut_end) exp_valid <= flags.tcp_match;
      else exp_valid <= '0;
      if (head || vs_shift || cut || rcut || cut_end || state.sqrcut_end) begin
        exp_data <= st_shift_reg[191:128];
      end
      if (head || cut_end) exp_empty <= 3'((5'd8 - {1'b0, info.rx_cnt[3:0]}) % 8);
      else exp_empty <= '0;
      // tally follows the registered masks one cycle later
      if (|exp_start && |exp_valid) exp_cnt <= tally_bytes;
      else if (|exp_valid) exp_cnt <= exp_cnt + tally_bytes;
    end
  end

  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] want);
    $display("Mismatch at %0t: %s = %h, expected %h", $time, sig, got, want);
    err_count++;
  endtask

  //////////////////////////////
  // output checks
  //////////////////////////////
  always @(negedge clk) begin
    if (check_on) begin
      check_count += 5;
      assert (sq_rx_start == exp_start)
        else report_mismatch("sq_rx_start", 64'(sq_rx_start), 64'(exp_start));
      assert (sq_rx_valid == exp_valid)
        else report_mismatch("sq_rx_valid", 64'(sq_rx_valid), 64'(exp_valid));
      assert (sq_rx_beat.data == exp_data)
        else report_mismatch("sq_rx_beat.data", sq_rx_beat.data, exp_data);
      assert (sq_rx_beat.empty == exp_empty)
        else report_mismatch("sq_rx_beat.empty", 64'(sq_rx_beat.empty), 64'(exp_empty));
      assert (sq_rx_cnt == exp_cnt)
        else report_mismatch("sq_rx_cnt", 64'(sq_rx_cnt), 64'(exp_cnt));
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles without finishing the tests", cycle_count);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////
  task automatic drive(input logic [5:0] strobes, input logic [5:0] shift_ccnt,
                       input logic [15:0] rx_cnt, input logic [15:0] sync_len,
                       input logic tags, input logic [5:0] sub_len);
    @(posedge clk);
    #1;
    state = cut_out_pkg::cut_state_t'(strobes);
    flags.cut_on = next_rand() & next_rand();
    flags.cut_first_on = next_rand();
    flags.tcp_match = next_rand();
    for (int i = 0; i < 6; i++) begin
      st_shift_reg[i*32 +: 32] = next_rand();
    end
    info.shift_ccnt = shift_ccnt;
    info.rx_cnt = rx_cnt;
    info.sync_len = sync_len;
    info.sync_first = tags ? 16'h0200 : 16'h0201;
    info.sync_four = tags ? 32'h0100044c : 32'h0100044d;
    info.frame_flag = 1'b1;
    info.sqid_flag = 1'b1;
    info.sub_len = sub_len;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
      state = '0;
    end
  endtask

  task automatic begin_test();
    checks_at_start = check_count;
    errs_at_start = err_count;
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("%s: %0d checks, %0d errors", name,
             check_count - checks_at_start, err_count - errs_at_start);
  endtask

  initial begin
    logic [31:0] r;
    state = '0;
    flags = '0;
    info = '0;
    st_shift_reg = '0;

    begin_test();
    wait (rst_n);
    check_on = 1'b1;
    @(negedge clk);
    check_count++;
    assert (sq_rx_start == '0 && sq_rx_valid == '0 && sq_rx_beat == '0 && sq_rx_cnt == '0)
      else begin
        $display("outputs not all zero after reset at %0t", $time);
        err_count++;
      end
    idle(2);
    end_test("reset");

    begin_test();
    drive(S_HEAD, 6'd20, 16'd13, 16'd0, 1'b0, 6'd0);
    drive(S_HEAD, 6'd5, 16'd13, 16'd0, 1'b0, 6'd0);
    drive(S_HEAD, 6'd16, 16'd16, 16'd0, 1'b0, 6'd0);
    idle(2);
    end_test("head cut");

    begin_test();
    drive(S_VSYNC, 6'd10, 16'd50, 16'd100, 1'b1, 6'd0);
    drive(S_VSYNC, 6'd10, 16'd50, 16'd100, 1'b0, 6'd0);
    drive(S_VSYNC, 6'd10, 16'd104, 16'd100, 1'b1, 6'd0);
    drive(S_VSYNC, 6'd4, 16'd3, 16'd100, 1'b1, 6'd0);
    drive(S_VSYNC, 6'd12, 16'd3, 16'd100, 1'b1, 6'd0);
    // every lane busy
    flags.cut_on = '1;
    idle(2);
    end_test("vsync");

    begin_test();
    drive(S_RCUT, 6'd10, 16'd0, 16'd0, 1'b0, 6'd0);
    drive(S_RCUT, 6'd3, 16'd0, 16'd0, 1'b0, 6'd0);
    drive(S_RCUT_END, 6'd10, 16'd0, 16'd0, 1'b0, 6'd6);
    drive(S_RCUT_END, 6'd4, 16'd0, 16'd0, 1'b0, 6'd6);
    idle(2);
    end_test("re-cut");

    begin_test();
    repeat (300) begin
      r = next_rand();
      drive(r[5:0], r[11:6], r[31] ? 16'(r[17:12]) : 16'(r[27:12]),
            16'(r[23:18]), r[24], r[30:25]);
      // often reduce to a single strobe
      if (r[29]) state = cut_out_pkg::cut_state_t'(6'b1 << (r[14:12] % 6));
      r = next_rand();
      info.frame_flag = |r[1:0];
      info.sqid_flag = |r[3:2];
      if (r[7:4] == 4'd0) flags.cut_on = '1;
    end
    idle(2);
    end_test("priority");

    begin_test();
    drive(S_HEAD, 6'd20, 16'd3, 16'd0, 1'b0, 6'd0);
    flags.cut_first_on[0] = 1'b1;
    repeat (3) begin
      drive(S_CUT, 6'd20, 16'd3, 16'd0, 1'b0, 6'd0);
      flags.cut_first_on[0] = 1'b1;
    end
    drive(S_CUT_END, 6'd20, 16'd5, 16'd0, 1'b0, 6'd0);
    flags.cut_first_on[0] = 1'b1;
    idle(3);
    @(negedge clk);
    check_count++;
    // 3 bytes, three full beats, then 5 bytes
    assert (sq_rx_cnt == 16'd32)
      else report_mismatch("sq_rx_cnt", 64'(sq_rx_cnt), 64'd32);
    end_test("byte tally");

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
